// ==== verilog/analogizer_pkg.sv ====
/*
  shared definitions for the handheld core io block
  bus widths, stick thresholds, controller codes and the settings word layout
  imported by every rtl module and by the testbench
*/
package analogizer_pkg;

  // word widths
  localparam int key_w        = 16;
  localparam int joy_w        = 32;
  localparam int bus_w        = 32;
  localparam int page_w       = 8;
  localparam int rgb_w        = 24;
  localparam int inc_w        = 40;
  localparam int video_type_w = 4;

  // d-pad positions inside a key bitmap
  localparam int DPAD_UP    = 0;
  localparam int DPAD_DOWN  = 1;
  localparam int DPAD_LEFT  = 2;
  localparam int DPAD_RIGHT = 3;

  // unsigned stick bytes, idle sits near 0x7f
  localparam logic [7:0] STICK_LOW  = 8'h40;
  localparam logic [7:0] STICK_HIGH = 8'hC0;

  typedef logic [4:0] cont_type_t;
  typedef logic [1:0] assign_t;

  // controller type codes
  localparam cont_type_t CONT_NONE     = 5'h00;
  localparam cont_type_t CONT_ANALOG_A = 5'h12;
  localparam cont_type_t CONT_ANALOG_B = 5'h13;

  // settings word fields
  localparam int CFG_TYPE_LSB   = 0;
  localparam int CFG_ASSIGN_LSB = 8;
  localparam int CFG_VIDEO_LSB  = 12;
  localparam int CFG_BLANK_BIT  = 16;
  localparam logic [bus_w-1:0] CFG_MASK = 32'h0001_FFFF;

  localparam logic [video_type_w-1:0] VIDEO_TYPE_PAL = 4'h4;

  // chroma phase steps for the y/c encoder
  localparam logic [inc_w-1:0] NTSC_PHASE_INC = 40'd40997409892;
  localparam logic [inc_w-1:0] PAL_PHASE_INC  = 40'd50779326758;

endpackage

// ==== verilog/analogizer_config.sv ====
/*
  video adapter settings register on its own host bridge page
  written by a single-cycle bridge strobe and read back through a combinational mux
  also decodes the fields and applies blanking and the ntsc/pal select to video
*/
`timescale 1ns/1ps

module analogizer_config #(
  parameter logic [analogizer_pkg::page_w-1:0] CONFIG_PAGE = 8'hF7
) (
  input  logic                               clk_74a,
  input  logic                               arst_n,
  input  logic [analogizer_pkg::bus_w-1:0]   bridge_addr,
  input  logic                               bridge_wr,
  input  logic [analogizer_pkg::bus_w-1:0]   bridge_wr_data,
  input  logic [analogizer_pkg::rgb_w-1:0]   rgb_in,
  output logic [analogizer_pkg::bus_w-1:0]   bridge_rd_data,
  output analogizer_pkg::cont_type_t         cont_type,
  output analogizer_pkg::assign_t            cont_assign,
  output logic [analogizer_pkg::rgb_w-1:0]   video_rgb,
  output logic [analogizer_pkg::inc_w-1:0]   chroma_phase_inc,
  output logic                               pal_flag
);

  import analogizer_pkg::*;

  // stored settings, only the masked bits ever hold ones
  logic [bus_w-1:0]        cfg_word;
  // top address byte selects our page
  logic                    page_hit;
  logic [video_type_w-1:0] video_type;
  logic                    blank_screen;

  ////////////////////////////////////////////////////////////////////////////
  // bridge access
  ////////////////////////////////////////////////////////////////////////////

  assign page_hit = (bridge_addr[bus_w-1 -: page_w] == CONFIG_PAGE);

  // write lands at the edge after the strobe
  always_ff @(posedge clk_74a or negedge arst_n) begin
    if (!arst_n) begin
      cfg_word <= '0;
    end else if (bridge_wr && page_hit) begin
      // unwritable bits are dropped here
      cfg_word <= bridge_wr_data & CFG_MASK;
    end
  end

  // read data follows the address directly
  // every page but ours reads as zero
  always_comb begin
    if (page_hit) begin
      bridge_rd_data = cfg_word;
    end else begin
      bridge_rd_data = '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // field decode
  ////////////////////////////////////////////////////////////////////////////

  // controller type, zero means snac off
  assign cont_type    = cfg_word[CFG_TYPE_LSB +: $bits(cont_type_t)];
  // low two bits of the assignment field only
  // upper pair is kept for readback
  assign cont_assign  = cfg_word[CFG_ASSIGN_LSB +: $bits(assign_t)];
  assign video_type   = cfg_word[CFG_VIDEO_LSB +: video_type_w];
  assign blank_screen = cfg_word[CFG_BLANK_BIT];

  ////////////////////////////////////////////////////////////////////////////
  // video side
  ////////////////////////////////////////////////////////////////////////////

  // handheld screen goes black while blanking is set
  assign video_rgb = blank_screen ? '0 : rgb_in;

  // only type 4 means pal
  assign pal_flag = (video_type == VIDEO_TYPE_PAL);

  // encoder phase step follows the standard
  assign chroma_phase_inc = pal_flag ? PAL_PHASE_INC : NTSC_PHASE_INC;

endmodule

// ==== verilog/snac_player.sv ====
/*
  capture of one snac controller port
  button and stick words pass a synchronizer chain, then one register stage
  analog controller types turn the left stick into d-pad bits
*/
`timescale 1ns/1ps

module snac_player #(
  parameter int SYNC_STAGES = 3
) (
  input  logic                               clk_74a,
  input  logic                               arst_n,
  input  logic [analogizer_pkg::key_w-1:0]   snac_btn,
  input  logic [analogizer_pkg::joy_w-1:0]   snac_joy,
  input  analogizer_pkg::cont_type_t         cont_type,
  output logic [analogizer_pkg::key_w-1:0]   player_word
);

  import analogizer_pkg::*;

  // left stick byte positions in the joy word
  localparam int STICK_X_LSB = 0;
  localparam int STICK_Y_LSB = 8;

  // synchronizer chains, stage 0 samples the pins
  logic [key_w-1:0] btn_sync [SYNC_STAGES];
  logic [joy_w-1:0] joy_sync [SYNC_STAGES];

  logic [key_w-1:0] btn_s;
  logic [7:0]       stick_x;
  logic [7:0]       stick_y;
  logic             is_analog;
  logic [key_w-1:0] stick_word;

  ////////////////////////////////////////////////////////////////////////////
  // input synchronizer
  ////////////////////////////////////////////////////////////////////////////

  // snac pins are asynchronous to clk_74a
  // needs at least two stages
  always_ff @(posedge clk_74a or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        btn_sync[i] <= '0;
        joy_sync[i] <= '0;
      end
    end else begin
      btn_sync[0] <= snac_btn;
      joy_sync[0] <= snac_joy;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        btn_sync[i] <= btn_sync[i-1];
        joy_sync[i] <= joy_sync[i-1];
      end
    end
  end

  assign btn_s   = btn_sync[SYNC_STAGES-1];
  assign stick_x = joy_sync[SYNC_STAGES-1][STICK_X_LSB +: 8];
  assign stick_y = joy_sync[SYNC_STAGES-1][STICK_Y_LSB +: 8];

  ////////////////////////////////////////////////////////////////////////////
  // stick to d-pad
  ////////////////////////////////////////////////////////////////////////////

  assign is_analog = (cont_type == CONT_ANALOG_A) || (cont_type == CONT_ANALOG_B);

  // upper buttons kept, d-pad replaced by thresholded stick
  // strict compares leave a dead zone between the limits
  always_comb begin
    stick_word             = btn_s;
    stick_word[DPAD_UP]    = (stick_y < STICK_LOW);
    stick_word[DPAD_DOWN]  = (stick_y > STICK_HIGH);
    stick_word[DPAD_LEFT]  = (stick_x < STICK_LOW);
    stick_word[DPAD_RIGHT] = (stick_x > STICK_HIGH);
  end

  // registered player word
  always_ff @(posedge clk_74a or negedge arst_n) begin
    if (!arst_n) begin
      player_word <= '0;
    end else begin
      player_word <= is_analog ? stick_word : btn_s;
    end
  end

endmodule

// ==== verilog/player_router.sv ====
/*
  routes snac player words and handheld keys to the two player controls
  picked by the controller type and the assignment mode
  both outputs are registered, one cycle from any input
*/
`timescale 1ns/1ps

module player_router (
  input  logic                               clk_74a,
  input  logic                               arst_n,
  input  analogizer_pkg::cont_type_t         cont_type,
  input  analogizer_pkg::assign_t            cont_assign,
  input  logic [analogizer_pkg::key_w-1:0]   snac1_word,
  input  logic [analogizer_pkg::key_w-1:0]   snac2_word,
  input  logic [analogizer_pkg::key_w-1:0]   cont1_key,
  input  logic [analogizer_pkg::key_w-1:0]   cont2_key,
  output logic [analogizer_pkg::key_w-1:0]   p1_controls,
  output logic [analogizer_pkg::key_w-1:0]   p2_controls
);

  import analogizer_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // control select
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_74a or negedge arst_n) begin
    if (!arst_n) begin
      p1_controls <= '0;
      p2_controls <= '0;
    end else if (cont_type == CONT_NONE) begin
      // snac off so the handheld drives both players
      p1_controls <= cont1_key;
      p2_controls <= cont2_key;
    end else begin
      case (cont_assign)
        2'd0: begin
          // snac 1 to player 1
          p1_controls <= snac1_word;
          p2_controls <= cont2_key;
        end
        2'd1: begin
          // snac 1 to player 2
          // d-pad conversion already applied upstream
          p1_controls <= cont1_key;
          p2_controls <= snac1_word;
        end
        2'd2: begin
          // both ports straight through
          p1_controls <= snac1_word;
          p2_controls <= snac2_word;
        end
        default: begin
          // ports swapped
          p1_controls <= snac2_word;
          p2_controls <= snac1_word;
        end
      endcase
    end
  end

endmodule

// ==== verilog/pocket_core_io.sv ====
/*
  core-owned part of the handheld top level
  settings register, two snac ports and the player control router
  instances and wires only
*/
`timescale 1ns/1ps

module pocket_core_io #(
  parameter logic [analogizer_pkg::page_w-1:0] CONFIG_PAGE = 8'hF7,
  parameter int                                SYNC_STAGES = 3
) (
  input  logic                               clk_74a,
  input  logic                               arst_n,
  input  logic [analogizer_pkg::bus_w-1:0]   bridge_addr,
  // part of the bridge port only, reads are not strobed
  input  logic                               bridge_rd,
  input  logic                               bridge_wr,
  input  logic [analogizer_pkg::bus_w-1:0]   bridge_wr_data,
  input  logic [analogizer_pkg::key_w-1:0]   cont1_key,
  input  logic [analogizer_pkg::key_w-1:0]   cont2_key,
  input  logic [analogizer_pkg::key_w-1:0]   snac1_btn,
  input  logic [analogizer_pkg::joy_w-1:0]   snac1_joy,
  input  logic [analogizer_pkg::key_w-1:0]   snac2_btn,
  input  logic [analogizer_pkg::joy_w-1:0]   snac2_joy,
  input  logic [analogizer_pkg::rgb_w-1:0]   rgb_in,
  output logic [analogizer_pkg::bus_w-1:0]   bridge_rd_data,
  output logic [analogizer_pkg::key_w-1:0]   p1_controls,
  output logic [analogizer_pkg::key_w-1:0]   p2_controls,
  output logic [analogizer_pkg::rgb_w-1:0]   video_rgb,
  output logic [analogizer_pkg::inc_w-1:0]   chroma_phase_inc,
  output logic                               pal_flag
);

  import analogizer_pkg::*;

  cont_type_t       cont_type;
  assign_t          cont_assign;
  logic [key_w-1:0] snac1_word;
  logic [key_w-1:0] snac2_word;

  // settings register and video side
  analogizer_config #(.CONFIG_PAGE(CONFIG_PAGE)) u_config (
    .clk_74a(clk_74a), .arst_n(arst_n),
    .bridge_addr(bridge_addr), .bridge_wr(bridge_wr), .bridge_wr_data(bridge_wr_data),
    .rgb_in(rgb_in), .bridge_rd_data(bridge_rd_data),
    .cont_type(cont_type), .cont_assign(cont_assign),
    .video_rgb(video_rgb), .chroma_phase_inc(chroma_phase_inc), .pal_flag(pal_flag)
  );

  // snac port 1
  snac_player #(.SYNC_STAGES(SYNC_STAGES)) u_snac1 (
    .clk_74a(clk_74a), .arst_n(arst_n),
    .snac_btn(snac1_btn), .snac_joy(snac1_joy),
    .cont_type(cont_type), .player_word(snac1_word)
  );

  // snac port 2
  snac_player #(.SYNC_STAGES(SYNC_STAGES)) u_snac2 (
    .clk_74a(clk_74a), .arst_n(arst_n),
    .snac_btn(snac2_btn), .snac_joy(snac2_joy),
    .cont_type(cont_type), .player_word(snac2_word)
  );

  // player control select
  player_router u_router (
    .clk_74a(clk_74a), .arst_n(arst_n),
    .cont_type(cont_type), .cont_assign(cont_assign),
    .snac1_word(snac1_word), .snac2_word(snac2_word),
    .cont1_key(cont1_key), .cont2_key(cont2_key),
    .p1_controls(p1_controls), .p2_controls(p2_controls)
  );

endmodule

// ==== bench/core_io_props.sv ====
/*
  concurrent checks bound onto the core io top level
  reset state of the player controls, zero read data off the settings page
*/
`timescale 1ns/1ps

module core_io_props #(
  parameter logic [analogizer_pkg::page_w-1:0] CONFIG_PAGE = 8'hF7
) (
  input logic                             clk_74a,
  input logic                             arst_n,
  input logic [analogizer_pkg::bus_w-1:0] bridge_addr,
  input logic [analogizer_pkg::bus_w-1:0] bridge_rd_data,
  input logic [analogizer_pkg::key_w-1:0] p1_controls,
  input logic [analogizer_pkg::key_w-1:0] p2_controls
);

  import analogizer_pkg::*;

  // first edge after release still sees the reset value
  assert property (@(posedge clk_74a) $rose(arst_n) |-> (p1_controls == '0 && p2_controls == '0))
    else $error("player controls not zero in the cycle after reset release");

  // foreign pages never show the settings word
  assert property (@(posedge clk_74a) disable iff (!arst_n)
      (bridge_addr[bus_w-1 -: page_w] != CONFIG_PAGE) |-> (bridge_rd_data == '0))
    else $error("bridge read data not zero on a foreign page");

endmodule

// ==== bench/core_io_checker.sv ====
/*
  watches the DUT ports and keeps its own copy of the settings word
  on each bench request it waits the given latency, predicts and compares
*/
`timescale 1ns/1ps

module core_io_checker #(
  parameter logic [analogizer_pkg::page_w-1:0] CONFIG_PAGE = 8'hF7
) (
  input  logic                             clk_74a,
  input  logic                             arst_n,
  input  logic                             bridge_wr,
  input  logic                             pal_flag,
  input  logic                             check_req,
  input  logic [analogizer_pkg::bus_w-1:0] bridge_addr, bridge_wr_data, bridge_rd_data,
  input  logic [analogizer_pkg::key_w-1:0] cont1_key, cont2_key, snac1_btn, snac2_btn,
  input  logic [analogizer_pkg::key_w-1:0] p1_controls, p2_controls,
  input  logic [analogizer_pkg::joy_w-1:0] snac1_joy, snac2_joy,
  input  logic [analogizer_pkg::rgb_w-1:0] rgb_in, video_rgb,
  input  logic [analogizer_pkg::inc_w-1:0] chroma_phase_inc,
  input  int                               check_id,
  input  int                               check_lat,
  output logic                             check_done,
  output int                               checks_run,
  output int                               checks_failed
);

  import analogizer_pkg::*;

  localparam int IDLE_LIMIT = 1000;

  // everything the DUT drives, in one word for compare and print
  typedef struct packed {
    logic [key_w-1:0] p1;
    logic [key_w-1:0] p2;
    logic [rgb_w-1:0] rgb;
    logic [inc_w-1:0] inc;
    logic             pal;
    logic [bus_w-1:0] rd;
  } expect_t;

  logic [bus_w-1:0] model_cfg;

  function automatic string test_name(input int id);
    case (id)
      0: return "reset_defaults";
      1: return "cfg_readback";
      2: return "foreign_page";
      3: return "snac_off_keys";
      4: return "digital_snac";
      5: return "analog_stick";
      default: return "video_settings";
    endcase
  endfunction

  // analog types replace the d-pad with the left stick, y in byte 1, x in byte 0
  function automatic logic [key_w-1:0] stick_to_pad(input logic [key_w-1:0] btn,
      input logic [joy_w-1:0] joy, input logic analog);
    logic [key_w-1:0] w;
    w = btn;
    if (analog) begin
      w[DPAD_UP]    = joy[15:8] < STICK_LOW;
      w[DPAD_DOWN]  = joy[15:8] > STICK_HIGH;
      w[DPAD_LEFT]  = joy[7:0] < STICK_LOW;
      w[DPAD_RIGHT] = joy[7:0] > STICK_HIGH;
    end
    return w;
  endfunction

  function automatic expect_t predict(
    input logic [bus_w-1:0] cfg,
    input logic [key_w-1:0] key1,
    input logic [key_w-1:0] key2,
    input logic [key_w-1:0] btn1,
    input logic [key_w-1:0] btn2,
    input logic [joy_w-1:0] joy1,
    input logic [joy_w-1:0] joy2,
    input logic [rgb_w-1:0] rgb,
    input logic [bus_w-1:0] addr
  );
    expect_t    e;
    cont_type_t ctype;
    logic       analog;
    logic [key_w-1:0] s1;
    logic [key_w-1:0] s2;
    ctype  = cfg[CFG_TYPE_LSB +: $bits(cont_type_t)];
    analog = (ctype == CONT_ANALOG_A) || (ctype == CONT_ANALOG_B);
    s1 = stick_to_pad(btn1, joy1, analog);
    s2 = stick_to_pad(btn2, joy2, analog);
    if (ctype == CONT_NONE) begin
      {e.p1, e.p2} = {key1, key2};
    end else begin
      case (cfg[CFG_ASSIGN_LSB +: 2])
        2'd0: {e.p1, e.p2} = {s1, key2};
        2'd1: {e.p1, e.p2} = {key1, s1};
        2'd2: {e.p1, e.p2} = {s1, s2};
        default: {e.p1, e.p2} = {s2, s1};
      endcase
    end
    e.rgb = cfg[CFG_BLANK_BIT] ? '0 : rgb;
    e.pal = (cfg[CFG_VIDEO_LSB +: video_type_w] == VIDEO_TYPE_PAL);
    e.inc = e.pal ? PAL_PHASE_INC : NTSC_PHASE_INC;
    e.rd  = (addr[bus_w-1 -: page_w] == CONFIG_PAGE) ? cfg : '0;
    return e;
  endfunction

  // settings copy, follows page-matched bridge writes
  always @(posedge clk_74a or negedge arst_n) begin
    if (!arst_n) begin
      model_cfg <= '0;
    end else if (bridge_wr && bridge_addr[bus_w-1 -: page_w] == CONFIG_PAGE) begin
      model_cfg <= bridge_wr_data & CFG_MASK;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare process
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int      waited;
    expect_t exp_v;
    expect_t act_v;
    check_done    = 1'b0;
    checks_run    = 0;
    checks_failed = 0;
    forever begin
      waited = 0;
      do begin
        @(posedge clk_74a);
        waited++;
      end while (check_req !== 1'b1 && waited < IDLE_LIMIT);
      if (check_req !== 1'b1) begin
        $display("checker got no request within %0d cycles", IDLE_LIMIT);
        checks_failed++;
      end else begin
        // first edge already counted, sample mid-cycle
        for (int n = 1; n < check_lat; n++) begin
          @(posedge clk_74a);
        end
        @(negedge clk_74a);
        exp_v = predict(model_cfg, cont1_key, cont2_key, snac1_btn, snac2_btn,
                        snac1_joy, snac2_joy, rgb_in, bridge_addr);
        act_v = {p1_controls, p2_controls, video_rgb, chroma_phase_inc, pal_flag,
                 bridge_rd_data};
        checks_run++;
        if (act_v !== exp_v) begin
          $display("Mismatch %s #%0d expected %h actual %h", test_name(check_id), checks_run,
                   exp_v, act_v);
          checks_failed++;
        end else begin
          $display("%s #%0d ok", test_name(check_id), checks_run);
        end
        check_done = 1'b1;
        @(posedge clk_74a);
        #2;
        check_done = 1'b0;
      end
    end
  end

endmodule

// ==== bench/tb_core_io.sv ====
/*
  top of the core io testbench
  drives reset, bridge writes, keys, snac ports and video
  asks the checker for a compare after each step and prints the closing counts
*/
`timescale 1ns/1ps

module tb_core_io;

  import analogizer_pkg::*;

  localparam logic [page_w-1:0] CFG_PAGE = 8'hF7;
  localparam int SYNC_N     = 3;
  // pins to controls through synchronizer, player word and router
  localparam int SNAC_LAT   = SYNC_N + 2;
  // routing follows two edges after a write returns
  localparam int CFG_LAT    = 2;
  localparam int WAIT_LIMIT = 50;

  logic             clk_74a = 1'b0;
  logic             arst_n;
  logic             bridge_rd;
  logic             bridge_wr;
  logic             pal_flag;
  logic [bus_w-1:0] bridge_addr, bridge_wr_data, bridge_rd_data;
  logic [key_w-1:0] cont1_key, cont2_key, snac1_btn, snac2_btn;
  logic [key_w-1:0] p1_controls, p2_controls;
  logic [joy_w-1:0] snac1_joy, snac2_joy;
  logic [rgb_w-1:0] rgb_in, video_rgb;
  logic [inc_w-1:0] chroma_phase_inc;
  // request handshake with the checker
  logic             check_req;
  logic             check_done;
  int               check_id;
  int               check_lat;
  int               checks_run;
  int               checks_failed;
  int               timeouts;

  always #10 clk_74a = ~clk_74a;

  pocket_core_io #(.CONFIG_PAGE(CFG_PAGE), .SYNC_STAGES(SYNC_N)) DUT (.*);

  core_io_checker #(.CONFIG_PAGE(CFG_PAGE)) u_checker (.*);

  bind pocket_core_io core_io_props #(.CONFIG_PAGE(CONFIG_PAGE)) u_props (
    .clk_74a(clk_74a), .arst_n(arst_n), .bridge_addr(bridge_addr),
    .bridge_rd_data(bridge_rd_data), .p1_controls(p1_controls), .p2_controls(p2_controls)
  );

  // inputs change 1 ns after the rising edge
  task automatic drive_slot();
    @(posedge clk_74a);
    #1;
  endtask

  task automatic bridge_write(input logic [bus_w-1:0] addr, input logic [bus_w-1:0] data);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    drive_slot();
    bridge_wr      = 1'b0;
  endtask

  task automatic random_inputs();
    cont1_key = 16'($urandom);
    cont2_key = 16'($urandom);
    snac1_btn = 16'($urandom);
    snac2_btn = 16'($urandom);
    snac1_joy = $urandom;
    snac2_joy = $urandom;
    rgb_in    = 24'($urandom);
  endtask

  // raise a request and hold inputs until the checker answers
  task automatic run_check(input int id, input int lat);
    int waited;
    waited    = 0;
    check_id  = id;
    check_lat = lat;
    check_req = 1'b1;
    drive_slot();
    check_req = 1'b0;
    while (check_done !== 1'b1 && waited < WAIT_LIMIT) begin
      @(posedge clk_74a);
      waited++;
    end
    if (check_done !== 1'b1) begin
      $display("checker did not answer request for test %0d", id);
      timeouts++;
    end
    #1;
  endtask

  initial begin
    logic [31:0] edge_pack;
    logic [7:0]  sx;
    logic [7:0]  sy;
    void'($urandom(33));
    {arst_n, bridge_rd, bridge_wr, check_req, check_id, check_lat, timeouts} = '0;
    {cont1_key, cont2_key, snac1_btn, snac2_btn, snac1_joy, snac2_joy} = '0;
    bridge_addr    = {CFG_PAGE, 24'h0};
    bridge_wr_data = '0;
    rgb_in         = 24'($urandom);
    repeat (3) @(posedge clk_74a);
    #1 arst_n = 1'b1;
    run_check(0, 0);

    // masked readback then foreign pages
    repeat (4) begin
      bridge_write({CFG_PAGE, 24'($urandom)}, $urandom);
      // read data must not depend on the read strobe
      bridge_rd = ~bridge_rd;
      run_check(1, CFG_LAT);
    end
    bridge_write({8'h5A, 24'($urandom)}, $urandom);
    bridge_addr = {CFG_PAGE, 24'h0};
    run_check(2, CFG_LAT);
    bridge_write({8'hF8, 24'($urandom)}, $urandom);
    run_check(2, 0);
    bridge_addr = {8'h00, 24'($urandom)};
    run_check(2, 0);

    // snac off with assign bits set but ignored
    bridge_write({CFG_PAGE, 24'h0}, 32'h0000_0300);
    repeat (4) begin
      random_inputs();
      run_check(3, 1);
    end

    // digital type, every assignment mode
    for (int mode = 0; mode < 4; mode++) begin
      bridge_write({CFG_PAGE, 24'h0}, 32'h0000_0001 | (32'(mode) << CFG_ASSIGN_LSB));
      repeat (2) begin
        random_inputs();
        run_check(4, SNAC_LAT);
      end
    end

    // both analog codes in mode 2 so both ports show
    for (int t = 0; t < 2; t++) begin
      bridge_write({CFG_PAGE, 24'h0}, 32'(t ? CONT_ANALOG_B : CONT_ANALOG_A) | 32'h0000_0200);
      edge_pack = 32'h3F40_C0C1;
      for (int i = 0; i < 8; i++) begin
        random_inputs();
        if (i < 4) begin
          sx = edge_pack[31:24];
          sy = edge_pack[23:16];
          edge_pack = {edge_pack[23:0], edge_pack[31:24]};
        end else begin
          sx = 8'($urandom);
          sy = 8'($urandom);
        end
        snac1_joy[15:0] = {sy, sx};
        snac2_joy[15:0] = {sx, sy};
        run_check(5, SNAC_LAT);
      end
    end

    // blank then pal then both then back to pass-through ntsc
    for (int v = 1; v < 5; v++) begin
      rgb_in = 24'($urandom);
      bridge_write({CFG_PAGE, 24'h0}, {15'h0, v[0], v[1] ? VIDEO_TYPE_PAL : 4'h0, 12'h0});
      run_check(6, 0);
    end

    drive_slot();
    $display("checks %0d, failed %0d, timeouts %0d", checks_run, checks_failed, timeouts);
    if (checks_failed == 0 && timeouts == 0 && checks_run > 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
verilog/analogizer_pkg.sv
verilog/analogizer_config.sv
verilog/snac_player.sv
verilog/player_router.sv
verilog/pocket_core_io.sv
bench/core_io_props.sv
bench/core_io_checker.sv
bench/tb_core_io.sv

// ==== Makefile ====
# verilator build and run of the core io testbench
SIM := obj_dir/Vtb_core_io
SRCS := $(shell cat vlog.f)

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

$(SIM): vlog.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_core_io -f vlog.f

clean:
	rm -rf obj_dir
